// ==== common/sdram_pkg.sv ====
`default_nettype none

package sdram_pkg;

   // Geometry of the 16-bit part
   localparam int BA_W   = 2;
   localparam int ROW_W  = 13;
   localparam int COL_W  = 9;
   localparam int HADR_W = BA_W + ROW_W + COL_W - 1;
   localparam int HDAT_W = 32;
   localparam int DQ_W   = 16;
   localparam int DQM_W  = DQ_W / 8;
   localparam int SEL_W  = HDAT_W / 8;

   // Timing in sdram_clk cycles
   localparam int CAS_LAT        = 2;
   localparam int T_RCD          = 2;
   localparam int T_RP           = 2;
   localparam int T_RFC          = 7;
   localparam int T_WR           = 2;
   localparam int T_MRD          = 2;
   localparam int INIT_WAIT      = 20;
   localparam int REFRESH_PERIOD = 150;

   // Command spacing after RD/WR with auto-precharge
   // A read holds off idle until its word has been acked
   localparam int RD_GAP = CAS_LAT + T_RP + 3;
   localparam int WR_GAP = T_WR + T_RP + 2;

   localparam int WAIT_W = $clog2(INIT_WAIT + 1);
   localparam int REF_W  = $clog2(REFRESH_PERIOD);

   // Burst length 2, sequential, CAS latency in A6:A4
   localparam logic [ROW_W-1:0] MODE_WORD = {3'b000, 1'b0, 2'b00, 3'(CAS_LAT), 1'b0, 3'b001};

   // RAS, CAS, WE
   localparam logic [2:0] CMD_NOP = 3'b111;
   localparam logic [2:0] CMD_ACT = 3'b011;
   localparam logic [2:0] CMD_RD  = 3'b101;
   localparam logic [2:0] CMD_WR  = 3'b100;
   localparam logic [2:0] CMD_PRE = 3'b010;
   localparam logic [2:0] CMD_REF = 3'b001;
   localparam logic [2:0] CMD_MRS = 3'b000;

   typedef struct packed {
      logic              port;
      logic              we;
      logic [SEL_W-1:0]  sel;
      logic [BA_W-1:0]   ba;
      logic [ROW_W-1:0]  row;
      logic [COL_W-2:0]  col_word;
      logic [HDAT_W-1:0] wdata;
   } sdram_req_t;

   typedef struct packed {
      logic             cs_n;
      logic [2:0]       cmd;
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] addr;
   } sdram_pad_t;

   localparam sdram_pad_t PAD_NOP = '{cs_n: 1'b0, cmd: CMD_NOP, ba: '0, addr: '0};

endpackage

`default_nettype wire

// ==== source/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
   input  wire                               sdram_clk,
   input  wire                               sdram_rst,
   input  wire [1:0][sdram_pkg::HADR_W-1:0]  wb_adr_i,
   input  wire [1:0][sdram_pkg::HDAT_W-1:0]  wb_dat_i,
   input  wire [1:0][sdram_pkg::SEL_W-1:0]   wb_sel_i,
   input  wire [1:0]                         wb_we_i,
   input  wire [1:0]                         wb_stb_i,
   input  wire [1:0]                         wb_cyc_i,
   output logic [1:0][sdram_pkg::HDAT_W-1:0] wb_dat_o,
   output logic [1:0]                        wb_ack_o,
   output sdram_pkg::sdram_req_t             req_o,
   output logic                              req_valid_o,
   input  wire                               req_taken_i,
   input  wire                               done_i,
   input  wire [sdram_pkg::HDAT_W-1:0]       rdata_i
);

   logic [1:0] pending;
   logic       pick;
   logic       last_port;
   logic       taken;

   assign pending = wb_stb_i & wb_cyc_i;

   // Both waiting, the port not served last goes first
   always_comb begin
      if (pending == 2'b11) begin
         pick = ~last_port;
      end else begin
         pick = pending[1];
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         req_valid_o <= 1'b0;
         taken       <= 1'b0;
         last_port   <= 1'b1;
      end else if (req_valid_o) begin
         if (done_i) begin
            req_valid_o <= 1'b0;
            taken       <= 1'b0;
            last_port   <= req_o.port;
         end else if (req_taken_i) begin
            taken <= 1'b1;
         end
      end else if (pending != 2'b00) begin
         req_valid_o <= 1'b1;
      end
   end

   // Word address splits into bank, row, column word
   always_ff @(posedge sdram_clk) begin
      if (!req_valid_o && (pending != 2'b00)) begin
         req_o.port                            <= pick;
         req_o.we                              <= wb_we_i[pick];
         req_o.sel                             <= wb_sel_i[pick];
         {req_o.ba, req_o.row, req_o.col_word} <= wb_adr_i[pick];
         req_o.wdata                           <= wb_dat_i[pick];
      end
   end

   // Ack only the granted port, and only for a request the FSM took
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         wb_ack_o[p] = done_i && taken && (req_o.port == p[0]);
         wb_dat_o[p] = wb_ack_o[p] ? rdata_i : '0;
      end
   end

endmodule

`default_nettype wire

// ==== sdram_fsm/sdram_cmd_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_fsm (
   input  wire                        sdram_clk,
   input  wire                        sdram_rst,
   input  wire sdram_pkg::sdram_req_t req_i,
   input  wire                        req_valid_i,
   output logic                       req_taken_o,
   output sdram_pkg::sdram_pad_t      pad_o,
   output logic                       rd_issue_o,
   output logic                       wr_issue_o
);
   import sdram_pkg::*;

   typedef enum logic [2:0] {
      ST_INIT,
      ST_INIT_PRE,
      ST_INIT_REF,
      ST_IDLE,
      ST_ACT,
      ST_RECOVER
   } state_t;

   state_t            state;
   state_t            state_d;
   logic [WAIT_W-1:0] cnt;
   logic [WAIT_W-1:0] cnt_d;
   logic              init_ref;
   logic              init_ref_d;
   sdram_pad_t        pad_d;
   logic              rd_d;
   logic              wr_d;
   logic [REF_W-1:0]  ref_cnt;
   logic              refresh_req;

   // Refresh request, set on count zero, cleared by REF
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt     <= REF_W'(REFRESH_PERIOD - 1);
         refresh_req <= 1'b0;
      end else if (ref_cnt == '0) begin
         ref_cnt     <= REF_W'(REFRESH_PERIOD - 1);
         refresh_req <= 1'b1;
      end else begin
         ref_cnt <= ref_cnt - 1'b1;
         if (pad_d.cmd == CMD_REF) begin
            refresh_req <= 1'b0;
         end
      end
   end

   assign req_taken_o = (state == ST_IDLE) && !refresh_req && req_valid_i;

   always_comb begin
      state_d    = state;
      cnt_d      = cnt;
      init_ref_d = init_ref;
      pad_d      = PAD_NOP;
      rd_d       = 1'b0;
      wr_d       = 1'b0;
      if (cnt != '0) begin
         cnt_d = cnt - 1'b1;
      end else begin
         case (state)
            ST_INIT: begin
               // Precharge all banks
               pad_d.cmd      = CMD_PRE;
               pad_d.addr[10] = 1'b1;
               cnt_d          = WAIT_W'(T_RP - 1);
               state_d        = ST_INIT_PRE;
            end
            ST_INIT_PRE: begin
               pad_d.cmd = CMD_REF;
               cnt_d     = WAIT_W'(T_RFC - 1);
               state_d   = ST_INIT_REF;
            end
            ST_INIT_REF: begin
               if (!init_ref) begin
                  pad_d.cmd  = CMD_REF;
                  cnt_d      = WAIT_W'(T_RFC - 1);
                  init_ref_d = 1'b1;
               end else begin
                  pad_d.cmd  = CMD_MRS;
                  pad_d.addr = MODE_WORD;
                  cnt_d      = WAIT_W'(T_MRD - 2);
                  state_d    = ST_RECOVER;
               end
            end
            ST_IDLE: begin
               if (refresh_req) begin
                  pad_d.cmd = CMD_REF;
                  cnt_d     = WAIT_W'(T_RFC - 2);
                  state_d   = ST_RECOVER;
               end else if (req_valid_i) begin
                  pad_d.cmd  = CMD_ACT;
                  pad_d.ba   = req_i.ba;
                  pad_d.addr = req_i.row;
                  cnt_d      = WAIT_W'(T_RCD - 1);
                  state_d    = ST_ACT;
               end
            end
            ST_ACT: begin
               // Column with A10 set for auto-precharge
               pad_d.cmd  = req_i.we ? CMD_WR : CMD_RD;
               pad_d.ba   = req_i.ba;
               pad_d.addr = {{(ROW_W - COL_W - 2){1'b0}}, 1'b1, 1'b0, req_i.col_word, 1'b0};
               rd_d       = !req_i.we;
               wr_d       = req_i.we;
               cnt_d      = req_i.we ? WAIT_W'(WR_GAP - 2) : WAIT_W'(RD_GAP - 2);
               state_d    = ST_RECOVER;
            end
            default: begin
               state_d = ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state      <= ST_INIT;
         cnt        <= WAIT_W'(INIT_WAIT - 1);
         init_ref   <= 1'b0;
         pad_o      <= PAD_NOP;
         rd_issue_o <= 1'b0;
         wr_issue_o <= 1'b0;
      end else begin
         state      <= state_d;
         cnt        <= cnt_d;
         init_ref   <= init_ref_d;
         pad_o      <= pad_d;
         rd_issue_o <= rd_d;
         wr_issue_o <= wr_d;
      end
   end

endmodule

`default_nettype wire

// ==== source/sdram_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_data_path (
   input  wire                          sdram_clk,
   input  wire                          sdram_rst,
   input  wire sdram_pkg::sdram_req_t   req_i,
   input  wire                          rd_issue_i,
   input  wire                          wr_issue_i,
   input  wire [sdram_pkg::DQ_W-1:0]    dq_i,
   output logic [sdram_pkg::DQ_W-1:0]   dq_o,
   output logic [sdram_pkg::DQM_W-1:0]  dqm_o,
   output logic                         dq_oe_o,
   output logic                         done_o,
   output logic [sdram_pkg::HDAT_W-1:0] rdata_o
);
   import sdram_pkg::*;

   logic [DQ_W-1:0]    dq_hi;
   logic [DQM_W-1:0]   dqm_hi;
   logic               wr_hi;
   logic [DQ_W-1:0]    dq_q;
   logic [CAS_LAT+1:0] rd_pipe;

   // Read beats trail the command by CL, the FSM may already be precharging
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_hi   <= 1'b0;
         rd_pipe <= '0;
         dq_oe_o <= 1'b0;
         done_o  <= 1'b0;
      end else begin
         wr_hi   <= wr_issue_i;
         rd_pipe <= {rd_pipe[CAS_LAT:0], rd_issue_i};
         dq_oe_o <= wr_issue_i | wr_hi;
         done_o  <= wr_hi | rd_pipe[CAS_LAT+1];
      end
   end

   // Low half first, byte selects become active-low masks
   always_ff @(posedge sdram_clk) begin
      if (wr_issue_i) begin
         dq_o   <= req_i.wdata[DQ_W-1:0];
         dqm_o  <= ~req_i.sel[DQM_W-1:0];
         dq_hi  <= req_i.wdata[HDAT_W-1:DQ_W];
         dqm_hi <= ~req_i.sel[SEL_W-1:DQM_W];
      end else if (wr_hi) begin
         dq_o  <= dq_hi;
         dqm_o <= dqm_hi;
      end else begin
         dqm_o <= '0;
      end
   end

   always_ff @(posedge sdram_clk) begin
      dq_q <= dq_i;
      if (rd_pipe[CAS_LAT]) begin
         rdata_o[DQ_W-1:0] <= dq_q;
      end
      if (rd_pipe[CAS_LAT+1]) begin
         rdata_o[HDAT_W-1:DQ_W] <= dq_q;
      end
   end

endmodule

`default_nettype wire

// ==== source/sdram_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top (
   input  wire                              sdram_clk,
   input  wire                              sdram_rst,
   input  wire [1:0][sdram_pkg::HADR_W-1:0] wb_adr_i,
   input  wire [1:0][sdram_pkg::HDAT_W-1:0] wb_dat_i,
   input  wire [1:0][sdram_pkg::SEL_W-1:0]  wb_sel_i,
   input  wire [1:0]                        wb_we_i,
   input  wire [1:0]                        wb_stb_i,
   input  wire [1:0]                        wb_cyc_i,
   output wire [1:0][sdram_pkg::HDAT_W-1:0] wb_dat_o,
   output wire [1:0]                        wb_ack_o,
   output wire sdram_pkg::sdram_pad_t       pad_o,
   output wire [sdram_pkg::DQ_W-1:0]        dq_o,
   output wire [sdram_pkg::DQM_W-1:0]       dqm_o,
   output wire                              dq_oe_o,
   input  wire [sdram_pkg::DQ_W-1:0]        dq_i,
   output wire                              cke_o
);
   import sdram_pkg::*;

   sdram_req_t        req;
   logic              req_valid;
   logic              req_taken;
   logic              rd_issue;
   logic              wr_issue;
   logic              done;
   logic [HDAT_W-1:0] rdata;

   port_arbiter u_decode (
      .sdram_clk   (sdram_clk),
      .sdram_rst   (sdram_rst),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_we_i     (wb_we_i),
      .wb_stb_i    (wb_stb_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .req_o       (req),
      .req_valid_o (req_valid),
      .req_taken_i (req_taken),
      .done_i      (done),
      .rdata_i     (rdata)
   );

   sdram_cmd_fsm u_execute (
      .sdram_clk   (sdram_clk),
      .sdram_rst   (sdram_rst),
      .req_i       (req),
      .req_valid_i (req_valid),
      .req_taken_o (req_taken),
      .pad_o       (pad_o),
      .rd_issue_o  (rd_issue),
      .wr_issue_o  (wr_issue)
   );

   sdram_data_path u_result (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .req_i      (req),
      .rd_issue_i (rd_issue),
      .wr_issue_i (wr_issue),
      .dq_i       (dq_i),
      .dq_o       (dq_o),
      .dqm_o      (dqm_o),
      .dq_oe_o    (dq_oe_o),
      .done_o     (done),
      .rdata_o    (rdata)
   );

   assign cke_o = 1'b1;

endmodule

`default_nettype wire

// ==== tb/sdram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
   input  wire                         sdram_clk,
   input  wire sdram_pkg::sdram_pad_t  pad_i,
   input  wire [sdram_pkg::DQ_W-1:0]   dq_i,
   input  wire [sdram_pkg::DQM_W-1:0]  dqm_i,
   input  wire                         dq_oe_i,
   input  wire                         cke_i,
   output logic [sdram_pkg::DQ_W-1:0]  dq_o
);
   import sdram_pkg::*;

   localparam int KEY_W = BA_W + ROW_W + COL_W;

   logic [DQ_W-1:0]    mem [logic [KEY_W-1:0]];
   logic [ROW_W-1:0]   open_row [1 << BA_W];
   logic [CAS_LAT-1:0] rd_pipe = '0;
   logic [1:0]         wr_pipe = '0;
   logic [KEY_W-1:0]   rd_key;
   logic [KEY_W-1:0]   wr_key;
   wire                cmd_ok = cke_i && !pad_i.cs_n;
   wire                rd_cmd = cmd_ok && (pad_i.cmd == CMD_RD);
   wire                wr_cmd = cmd_ok && (pad_i.cmd == CMD_WR);

   initial dq_o = '0;

   // Unwritten cells read back as a pattern of the whole address
   function automatic logic [DQ_W-1:0] read_word(input logic [KEY_W-1:0] key);
      if (mem.exists(key)) begin
         return mem[key];
      end
      return key[DQ_W-1:0] ^ DQ_W'(key >> DQ_W) ^ 16'h5a5a;
   endfunction

   task automatic store_beat(input logic [KEY_W-1:0] key, input logic [DQ_W-1:0] data,
                             input logic [DQM_W-1:0] mask);
      logic [DQ_W-1:0] word;
      word = read_word(key);
      for (int b = 0; b < DQM_W; b++) begin
         if (!mask[b]) begin
            word[8*b +: 8] = data[8*b +: 8];
         end
      end
      mem[key] = word;
   endtask

   always @(posedge sdram_clk) begin
      rd_pipe <= {rd_pipe[CAS_LAT-2:0], rd_cmd};
      wr_pipe <= {wr_pipe[0], wr_cmd};
      if (cmd_ok && pad_i.cmd == CMD_ACT) begin
         open_row[pad_i.ba] <= pad_i.addr;
      end
      if (rd_cmd) begin
         rd_key <= {pad_i.ba, open_row[pad_i.ba], pad_i.addr[COL_W-1:0]};
      end
      if (wr_cmd) begin
         wr_key <= {pad_i.ba, open_row[pad_i.ba], pad_i.addr[COL_W-1:0]};
      end
      // Write beats trail the WR command by one and two cycles
      if (wr_pipe[0] && dq_oe_i) begin
         store_beat(wr_key, dq_i, dqm_i);
      end
      if (wr_pipe[1] && dq_oe_i) begin
         store_beat(wr_key | KEY_W'(1), dq_i, dqm_i);
      end
      // Burst of two, first beat valid CL edges after the command
      if (rd_pipe[CAS_LAT-2]) begin
         dq_o <= read_word(rd_key);
      end else if (rd_pipe[CAS_LAT-1]) begin
         dq_o <= read_word(rd_key | KEY_W'(1));
      end else begin
         dq_o <= 16'hdead;
      end
   end

endmodule

`default_nettype wire

// ==== tb/sdram_ctrl_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_chk (
   input wire                        sdram_clk,
   input wire                        sdram_rst,
   input wire sdram_pkg::sdram_pad_t pad_i,
   input wire                        dq_oe_i,
   input wire [1:0]                  wb_ack_i,
   input wire [1:0]                  wb_stb_i
);
   import sdram_pkg::*;

   // Longest stretch the FSM can spend in one access before idle
   localparam int ACCESS_LEN = T_RCD + RD_GAP + 6;

   int              fail_count = 0;
   int              since_ref;
   logic            mrs_seen;
   logic            req_seen;
   wire [2:0]       cmd = pad_i.cmd;
   wire [BA_W-1:0]  ba = pad_i.ba;
   wire             rw_cmd = (cmd == CMD_RD) || (cmd == CMD_WR);

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         mrs_seen  <= 1'b0;
         req_seen  <= 1'b0;
         since_ref <= 0;
      end else begin
         if (cmd == CMD_MRS) begin
            mrs_seen <= 1'b1;
         end
         if (wb_stb_i != 2'b00) begin
            req_seen <= 1'b1;
         end
         since_ref <= (cmd == CMD_REF) ? 0 : since_ref + 1;
      end
   end

   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    !mrs_seen |-> (cmd != CMD_ACT) && !rw_cmd)
      else begin
         fail_count++;
         $error("ACT, RD or WR issued before the mode register write");
      end

   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    !req_seen |-> !dq_oe_i && (wb_ack_i == 2'b00))
      else begin
         fail_count++;
         $error("Data enable or acknowledge active before any request");
      end

   // An ack goes to one port only, and only to a port holding its strobe
   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    (wb_ack_i != 2'b11) && ((wb_ack_i & ~wb_stb_i) == 2'b00))
      else begin
         fail_count++;
         $error("Acknowledge on both ports at once or on a port with no request");
      end

   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    mrs_seen |-> since_ref <= REFRESH_PERIOD + ACCESS_LEN)
      else begin
         fail_count++;
         $error("Refresh interval exceeded the refresh period plus one access");
      end

   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    rw_cmd |-> since_ref >= T_RFC - 1)
      else begin
         fail_count++;
         $error("Read or write issued too soon after a refresh");
      end

   assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                    rw_cmd |-> ($past(cmd, T_RCD) == CMD_ACT) && ($past(ba, T_RCD) == ba))
      else begin
         fail_count++;
         $error("Read or write not preceded by an activate on its bank at tRCD");
      end

endmodule

bind sdram_ctrl_top sdram_ctrl_chk chk (
   .sdram_clk (sdram_clk),
   .sdram_rst (sdram_rst),
   .pad_i     (pad_o),
   .dq_oe_i   (dq_oe_o),
   .wb_ack_i  (wb_ack_o),
   .wb_stb_i  (wb_stb_i)
);

`default_nettype wire

// ==== tb/tb_sdram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;
   import sdram_pkg::*;

   localparam int N_BASIC  = 8;
   localparam int N_MASK   = 4;
   localparam int N_DUAL   = 6;
   localparam int N_LONG   = 40;
   localparam int N_ACCESS = 2 * (N_BASIC + N_MASK) + 4 * N_DUAL + N_LONG;
   // Each access stays well under 40 cycles, plus init and refresh slack
   localparam int TIMEOUT_CYCLES = N_ACCESS * 40 + INIT_WAIT + 400;

   logic                   sdram_clk = 1'b0;
   logic                   sdram_rst = 1'b1;
   logic [1:0][HADR_W-1:0] wb_adr = '0;
   logic [1:0][HDAT_W-1:0] wb_dat = '0;
   logic [1:0][SEL_W-1:0]  wb_sel = '0;
   logic [1:0]             wb_we = '0;
   logic [1:0]             wb_stb = '0;
   logic [1:0]             wb_cyc = '0;
   logic [1:0][HDAT_W-1:0] wb_dat_rd;
   logic [1:0]             wb_ack;
   sdram_pad_t             pad;
   logic [DQ_W-1:0]        dq_wr;
   logic [DQ_W-1:0]        dq_rd;
   logic [DQM_W-1:0]       dqm;
   logic                   dq_oe;
   logic                   cke;

   logic [HDAT_W-1:0]      shadow [logic [HADR_W-1:0]];
   logic [HADR_W-1:0]      written [2][$];
   logic [1:0][HDAT_W-1:0] expect_dat = '0;
   int                     errors = 0;
   int                     cycles = 0;

   sdram_ctrl_top uut (
      .sdram_clk (sdram_clk),
      .sdram_rst (sdram_rst),
      .wb_adr_i  (wb_adr),
      .wb_dat_i  (wb_dat),
      .wb_sel_i  (wb_sel),
      .wb_we_i   (wb_we),
      .wb_stb_i  (wb_stb),
      .wb_cyc_i  (wb_cyc),
      .wb_dat_o  (wb_dat_rd),
      .wb_ack_o  (wb_ack),
      .pad_o     (pad),
      .dq_o      (dq_wr),
      .dqm_o     (dqm),
      .dq_oe_o   (dq_oe),
      .dq_i      (dq_rd),
      .cke_o     (cke)
   );

   sdram_model mem_model (
      .sdram_clk (sdram_clk),
      .pad_i     (pad),
      .dq_i      (dq_wr),
      .dqm_i     (dqm),
      .dq_oe_i   (dq_oe),
      .cke_i     (cke),
      .dq_o      (dq_rd)
   );

   always #20 sdram_clk = ~sdram_clk;

   for (genvar p = 0; p < 2; p++) begin : g_read_check
      assert property (@(posedge sdram_clk) disable iff (sdram_rst)
                       wb_ack[p] && !wb_we[p] |-> wb_dat_rd[p] == expect_dat[p])
         else begin
            errors++;
            $display("Error wb_dat_o[%0d]: got 0x%08h, expected 0x%08h", p,
                     $sampled(wb_dat_rd[p]), $sampled(expect_dat[p]));
         end
   end

   always @(posedge sdram_clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: a request was not acknowledged within %0d cycles", cycles);
         $display("Run stopped with %0d read data errors and %0d protocol errors",
                  errors, uut.chk.fail_count);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   function automatic logic [HDAT_W-1:0] merge_bytes(input logic [HDAT_W-1:0] old_word,
                                                     input logic [HDAT_W-1:0] new_word,
                                                     input logic [SEL_W-1:0]  sel);
      logic [HDAT_W-1:0] word;
      word = old_word;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) begin
            word[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return word;
   endfunction

   // Port number in the address LSB keeps the two ports on separate words
   function automatic logic [HADR_W-1:0] random_addr(input int p);
      logic [HADR_W-1:0] a;
      a = HADR_W'($urandom);
      a[0] = p[0];
      return a;
   endfunction

   task automatic bus_access(input int p, input logic we, input logic [HADR_W-1:0] adr,
                             input logic [HDAT_W-1:0] dat, input logic [SEL_W-1:0] sel);
      logic [HDAT_W-1:0] old_word;
      @(posedge sdram_clk);
      #2;
      old_word = shadow.exists(adr) ? shadow[adr] : '0;
      if (we) begin
         shadow[adr] = merge_bytes(old_word, dat, sel);
         written[p].push_back(adr);
      end else begin
         expect_dat[p] = old_word;
      end
      wb_adr[p] = adr;
      wb_dat[p] = dat;
      wb_sel[p] = sel;
      wb_we[p]  = we;
      wb_stb[p] = 1'b1;
      wb_cyc[p] = 1'b1;
      do @(posedge sdram_clk); while (!wb_ack[p]);
      #2;
      wb_stb[p] = 1'b0;
      wb_cyc[p] = 1'b0;
      wb_we[p]  = 1'b0;
   endtask

   task automatic port_traffic(input int p, input int n);
      logic [HADR_W-1:0] adr;
      for (int i = 0; i < n; i++) begin
         adr = random_addr(p);
         bus_access(p, 1'b1, adr, $urandom, 4'hf);
         bus_access(p, 1'b0, adr, '0, 4'hf);
      end
   endtask

   initial begin
      logic [HADR_W-1:0] adr;
      int                p;
      void'($urandom(32'he643));
      repeat (10) @(posedge sdram_clk);
      #2;
      sdram_rst = 1'b0;

      port_traffic(0, N_BASIC);

      // Partial masks over words already written on port 0
      for (int i = 0; i < N_MASK; i++) begin
         adr = written[0][$urandom_range(written[0].size() - 1)];
         bus_access(0, 1'b1, adr, $urandom, SEL_W'($urandom_range(14, 1)));
         bus_access(0, 1'b0, adr, '0, 4'hf);
      end

      fork
         port_traffic(0, N_DUAL);
         port_traffic(1, N_DUAL);
      join

      // Mixed run long enough to span several refresh periods
      for (int i = 0; i < N_LONG; i++) begin
         p = int'($urandom_range(1));
         if ($urandom_range(1) == 1) begin
            bus_access(p, 1'b1, random_addr(p), $urandom, 4'hf);
         end else begin
            adr = written[p][$urandom_range(written[p].size() - 1)];
            bus_access(p, 1'b0, adr, '0, 4'hf);
         end
      end

      repeat (5) @(posedge sdram_clk);
      $display("Run finished with %0d read data errors and %0d protocol errors",
               errors, uut.chk.fail_count);
      if (errors == 0 && uut.chk.fail_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
common/sdram_pkg.sv
source/port_arbiter.sv
sdram_fsm/sdram_cmd_fsm.sv
source/sdram_data_path.sv
source/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/sdram_ctrl_chk.sv
tb/tb_sdram_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_sdram_ctrl -f src.f -o tb_sdram_ctrl > build.log 2>&1 \
   && ./obj_dir/tb_sdram_ctrl +verilator+error+limit+1000 > sim.log 2>&1
grep -q "NO ERRORS" sim.log 2>/dev/null && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
